// File: verilog/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath widths
`define RV_XLEN        32
`define RV_REG_COUNT   32
`define RV_REG_ADDR_W  5

// first fetch after reset
`define RV_RESET_PC    32'h8000_0000

`define RV_NOP         32'h0000_0013  // addi x0, x0, 0

// major opcodes, inst[6:0]
`define RV_OP_REG      7'b0110011
`define RV_OP_IMM      7'b0010011
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011

`endif

// File: verilog/rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]       word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // immediate layout per instruction format
    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {
        A_REG, A_PC, A_ZERO
    } alu_a_sel_t;

    // register write-back source
    typedef enum logic [1:0] {
        WB_ALU, WB_LOAD, WB_LINK
    } wb_sel_t;

    typedef enum logic [1:0] {
        PC_SEQ, PC_JUMP, PC_JALR, PC_BRANCH
    } pc_sel_t;

endpackage

`default_nettype wire

// File: verilog/rv_control.sv
`default_nettype none

`include "rv_defs.svh"

module rv_control (
    input  logic               reset,
    input  logic [6:0]         opcode,
    input  logic [2:0]         funct3,
    input  logic [6:0]         funct7,
    output rv_pkg::inst_fmt_t  fmt,
    output rv_pkg::alu_op_t    alu_op,
    output rv_pkg::alu_a_sel_t alu_a_sel,
    output logic               alu_b_imm,
    output rv_pkg::wb_sel_t    wb_sel,
    output rv_pkg::pc_sel_t    pc_sel,
    output logic               reg_we,
    output logic               dmem_we
);
    logic reg_write;
    logic mem_write;
    logic is_alu_op;   // reg or imm arithmetic

    always_comb begin
        fmt       = rv_pkg::FMT_R;
        alu_a_sel = rv_pkg::A_REG;
        alu_b_imm = 1'b0;
        wb_sel    = rv_pkg::WB_ALU;
        pc_sel    = rv_pkg::PC_SEQ;
        reg_write = 1'b0;
        mem_write = 1'b0;
        is_alu_op = 1'b0;
        case (opcode)
            `RV_OP_REG: begin
                reg_write = 1'b1;
                is_alu_op = 1'b1;
            end
            `RV_OP_IMM: begin
                fmt       = rv_pkg::FMT_I;
                alu_b_imm = 1'b1;
                reg_write = 1'b1;
                is_alu_op = 1'b1;
            end
            `RV_OP_LUI: begin
                fmt       = rv_pkg::FMT_U;
                alu_a_sel = rv_pkg::A_ZERO;
                alu_b_imm = 1'b1;
                reg_write = 1'b1;
            end
            `RV_OP_AUIPC: begin
                fmt       = rv_pkg::FMT_U;
                alu_a_sel = rv_pkg::A_PC;
                alu_b_imm = 1'b1;
                reg_write = 1'b1;
            end
            `RV_OP_JAL: begin
                fmt       = rv_pkg::FMT_J;
                alu_a_sel = rv_pkg::A_PC;
                alu_b_imm = 1'b1;
                wb_sel    = rv_pkg::WB_LINK;
                pc_sel    = rv_pkg::PC_JUMP;
                reg_write = 1'b1;
            end
            `RV_OP_JALR: begin
                fmt       = rv_pkg::FMT_I;
                alu_b_imm = 1'b1;
                wb_sel    = rv_pkg::WB_LINK;
                pc_sel    = rv_pkg::PC_JALR;
                reg_write = 1'b1;
            end
            `RV_OP_BRANCH: begin
                // alu forms pc + offset, pc unit decides
                fmt       = rv_pkg::FMT_B;
                alu_a_sel = rv_pkg::A_PC;
                alu_b_imm = 1'b1;
                pc_sel    = rv_pkg::PC_BRANCH;
            end
            `RV_OP_LOAD: begin
                fmt       = rv_pkg::FMT_I;
                alu_b_imm = 1'b1;
                wb_sel    = rv_pkg::WB_LOAD;
                reg_write = 1'b1;
            end
            `RV_OP_STORE: begin
                fmt       = rv_pkg::FMT_S;
                alu_b_imm = 1'b1;
                mem_write = 1'b1;
            end
            default: ;  // executes as nop
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (is_alu_op) begin
            case (funct3)
                3'b000: begin
                    // sub only exists in register form
                    if (opcode == `RV_OP_REG && funct7 == 7'b0100000)
                        alu_op = rv_pkg::ALU_SUB;
                end
                3'b001: alu_op = rv_pkg::ALU_SLL;
                3'b010: alu_op = rv_pkg::ALU_SLT;
                3'b011: alu_op = rv_pkg::ALU_SLTU;
                3'b100: alu_op = rv_pkg::ALU_XOR;
                3'b101: alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110: alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

    assign reg_we  = reg_write & ~reset;
    assign dmem_we = mem_write & ~reset;

endmodule

`default_nettype wire

// File: verilog/rv_imm_gen.sv
`default_nettype none

`include "rv_defs.svh"

module rv_imm_gen (
    input  rv_pkg::word_t     inst,
    input  rv_pkg::inst_fmt_t fmt,
    output rv_pkg::word_t     imm
);
    logic sign;

    assign sign = inst[`RV_XLEN-1];

    always_comb begin
        case (fmt)
            rv_pkg::FMT_I: imm = {{20{sign}}, inst[31:20]};
            rv_pkg::FMT_S: imm = {{20{sign}}, inst[31:25], inst[11:7]};
            rv_pkg::FMT_B: begin
                // offset in units of 2 bytes
                imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_pkg::FMT_U: imm = {inst[31:12], 12'h000};
            rv_pkg::FMT_J: begin
                imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;  // r-type has none
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
    input  logic              clk,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    rv_pkg::word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: verilog/rv_alu.sv
`default_nettype none

`include "rv_defs.svh"

module rv_alu (
    input  rv_pkg::alu_op_t    alu_op,
    input  rv_pkg::alu_a_sel_t alu_a_sel,
    input  logic               alu_b_imm,
    input  rv_pkg::word_t      rs1_data,
    input  rv_pkg::word_t      rs2_data,
    input  rv_pkg::word_t      imm,
    input  rv_pkg::word_t      pc,
    output rv_pkg::word_t      result
);
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    logic [4:0]    shamt;

    always_comb begin
        case (alu_a_sel)
            rv_pkg::A_PC:   a = pc;
            rv_pkg::A_ZERO: a = '0;  // lui
            default:        a = rs1_data;
        endcase
    end

    assign b     = alu_b_imm ? imm : rs2_data;
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, a < b};
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            rv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_AND:  result = a & b;
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_pc_unit.sv
`default_nettype none

`include "rv_defs.svh"

module rv_pc_unit (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::pc_sel_t pc_sel,
    input  logic [2:0]      funct3,
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    input  rv_pkg::word_t   target,
    output rv_pkg::word_t   pc,
    output rv_pkg::word_t   pc_plus4
);
    rv_pkg::word_t next_pc;
    logic          taken;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (funct3)
            3'b000: taken = (rs1_data == rs2_data);
            3'b001: taken = (rs1_data != rs2_data);
            3'b100: taken = ($signed(rs1_data) <  $signed(rs2_data));
            3'b101: taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110: taken = (rs1_data <  rs2_data);
            3'b111: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (pc_sel)
            rv_pkg::PC_JUMP:   next_pc = target;
            rv_pkg::PC_JALR:   next_pc = {target[`RV_XLEN-1:1], 1'b0};
            rv_pkg::PC_BRANCH: next_pc = taken ? target : pc_plus4;
            default:           next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) pc <= `RV_RESET_PC;
        else       pc <= next_pc;
    end

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`default_nettype none

`include "rv_defs.svh"

module rv_core (
    input  logic          clk,
    input  logic          reset,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    output logic          dmem_we,
    input  rv_pkg::word_t dmem_rdata
);
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv_pkg::reg_addr_t  rd;
    rv_pkg::reg_addr_t  rs1;
    rv_pkg::reg_addr_t  rs2;

    rv_pkg::inst_fmt_t  fmt;
    rv_pkg::alu_op_t    alu_op;
    rv_pkg::alu_a_sel_t alu_a_sel;
    logic               alu_b_imm;
    rv_pkg::wb_sel_t    wb_sel;
    rv_pkg::pc_sel_t    pc_sel;
    logic               reg_we;

    rv_pkg::word_t      imm;
    rv_pkg::word_t      rs1_data;
    rv_pkg::word_t      rs2_data;
    rv_pkg::word_t      alu_result;
    rv_pkg::word_t      pc;
    rv_pkg::word_t      pc_plus4;
    rv_pkg::word_t      wb_data;

    // instruction fields
    assign opcode = imem_data[6:0];
    assign rd     = imem_data[11:7];
    assign funct3 = imem_data[14:12];
    assign rs1    = imem_data[19:15];
    assign rs2    = imem_data[24:20];
    assign funct7 = imem_data[31:25];

    rv_control control_i (
        .reset(reset), .opcode(opcode), .funct3(funct3), .funct7(funct7),
        .fmt(fmt), .alu_op(alu_op), .alu_a_sel(alu_a_sel), .alu_b_imm(alu_b_imm),
        .wb_sel(wb_sel), .pc_sel(pc_sel), .reg_we(reg_we), .dmem_we(dmem_we)
    );

    rv_imm_gen imm_gen_i (.inst(imem_data), .fmt(fmt), .imm(imm));

    rv_regfile regfile_i (
        .clk(clk), .we(reg_we), .waddr(rd), .wdata(wb_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    rv_alu alu_i (
        .alu_op(alu_op), .alu_a_sel(alu_a_sel), .alu_b_imm(alu_b_imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc),
        .result(alu_result)
    );

    rv_pc_unit pc_unit_i (
        .clk(clk), .reset(reset), .pc_sel(pc_sel), .funct3(funct3),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .target(alu_result),
        .pc(pc), .pc_plus4(pc_plus4)
    );

    // write-back select
    always_comb begin
        case (wb_sel)
            rv_pkg::WB_LOAD: wb_data = dmem_rdata;
            rv_pkg::WB_LINK: wb_data = pc_plus4;  // jal / jalr return address
            default:         wb_data = alu_result;
        endcase
    end

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam time HALF_PERIOD = 50ns;  // 100 ns period

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: testbench/rv_core_assert.sv
`default_nettype none

module rv_core_assert (
    input logic          clk,
    input logic          reset,
    input rv_pkg::word_t imem_addr,
    input logic          dmem_we
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;  // read by the testbench at the end

    no_store_in_reset: assert property (@(posedge clk) reset |-> !dmem_we)
        else begin
            $error("dmem_we high while reset is asserted");
            failures++;
        end

    // pc only moves in whole words
    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("imem_addr %h is not word aligned", imem_addr);
            failures++;
        end

    store_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(dmem_we))
        else begin
            $error("dmem_we is unknown after reset");
            failures++;
        end

endmodule

bind rv_core rv_core_assert core_assert_i (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .dmem_we(dmem_we)
);

`default_nettype wire

// File: testbench/rv_core_tb.sv
`default_nettype none

`include "rv_defs.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int  RESET_CYCLES = 16;
    localparam int  SLACK_CYCLES = 20;
    localparam time DRIVE_DELAY  = 10ns;
    localparam time SAMPLE_DELAY = 80ns;  // lands just before the next edge

    logic          clk;
    logic          reset;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_data;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    logic          dmem_we;
    rv_pkg::word_t dmem_rdata;

    // trace table, one entry per executed instruction
    rv_pkg::word_t row_pc[$];
    rv_pkg::word_t row_inst[$];
    rv_pkg::word_t row_ldata[$];
    logic          row_we[$];
    rv_pkg::word_t row_addr[$];
    rv_pkg::word_t row_wdata[$];

    int errors      = 0;
    int checks      = 0;
    int cycles      = 0;
    int cycle_limit = RESET_CYCLES + SLACK_CYCLES;

    tb_clock clock_i (.clk(clk));

    rv_core dut_i (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    function automatic rv_pkg::word_t encode_r(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
        input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic rv_pkg::word_t encode_i(input int imm, input rv_pkg::reg_addr_t rs1,
        input logic [2:0] f3, input rv_pkg::reg_addr_t rd, input logic [6:0] op);
        logic [31:0] v;
        v = imm;
        return {v[11:0], rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t encode_s(input int imm, input rv_pkg::reg_addr_t rs2,
        input rv_pkg::reg_addr_t rs1);
        logic [31:0] v;
        v = imm;
        return {v[11:5], rs2, rs1, 3'b010, v[4:0], `RV_OP_STORE};  // sw only
    endfunction

    function automatic rv_pkg::word_t encode_b(input int imm, input rv_pkg::reg_addr_t rs2,
        input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], `RV_OP_BRANCH};
    endfunction

    function automatic rv_pkg::word_t encode_u(input int imm20, input rv_pkg::reg_addr_t rd,
        input logic [6:0] op);
        logic [31:0] v;
        v = imm20;
        return {v[19:0], rd, op};
    endfunction

    function automatic rv_pkg::word_t encode_j(input int imm, input rv_pkg::reg_addr_t rd);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic add_row(input rv_pkg::word_t pc_off, input rv_pkg::word_t inst,
        input rv_pkg::word_t ldata, input logic we, input rv_pkg::word_t addr,
        input rv_pkg::word_t wdata);
        row_pc.push_back(`RV_RESET_PC + pc_off);
        row_inst.push_back(inst);
        row_ldata.push_back(ldata);
        row_we.push_back(we);
        row_addr.push_back(addr);
        row_wdata.push_back(wdata);
    endtask

    task automatic add_op(input rv_pkg::word_t pc_off, input rv_pkg::word_t inst);
        add_row(pc_off, inst, '0, 1'b0, '0, '0);
    endtask

    task automatic add_store(input rv_pkg::word_t pc_off, input rv_pkg::word_t inst,
        input rv_pkg::word_t addr, input rv_pkg::word_t wdata);
        add_row(pc_off, inst, '0, 1'b1, addr, wdata);
    endtask

    // x1 = 0x1000 is the store base, x2 = 100, x3 = -7
    task automatic build_trace();
        add_op('h00, encode_u('h00001, 1, `RV_OP_LUI));
        add_store('h04, encode_s(0, 1, 1), 32'h0000_1000, 32'h0000_1000);
        add_op('h08, encode_i(100, 0, 3'b000, 2, `RV_OP_IMM));
        add_op('h0c, encode_i(-7, 0, 3'b000, 3, `RV_OP_IMM));
        add_op('h10, encode_r(7'h00, 3, 2, 3'b000, 4));            // add
        add_store('h14, encode_s(4, 4, 1), 32'h0000_1004, 32'h0000_005d);
        add_op('h18, encode_r(7'h20, 3, 2, 3'b000, 5));            // sub
        add_store('h1c, encode_s(8, 5, 1), 32'h0000_1008, 32'h0000_006b);
        add_op('h20, encode_i(4, 3, 3'b001, 6, `RV_OP_IMM));       // slli
        add_store('h24, encode_s(12, 6, 1), 32'h0000_100c, 32'hffff_ff90);
        add_op('h28, encode_r(7'h00, 2, 3, 3'b010, 7));            // slt, signed -7 < 100
        add_store('h2c, encode_s(16, 7, 1), 32'h0000_1010, 32'h0000_0001);
        add_op('h30, encode_i(-7, 2, 3'b011, 8, `RV_OP_IMM));      // sltiu
        add_store('h34, encode_s(20, 8, 1), 32'h0000_1014, 32'h0000_0001);
        add_op('h38, encode_i('h0f0, 2, 3'b100, 9, `RV_OP_IMM));   // xori
        add_store('h3c, encode_s(24, 9, 1), 32'h0000_1018, 32'h0000_0094);
        add_op('h40, encode_i(4, 3, 3'b101, 10, `RV_OP_IMM));      // srli
        add_store('h44, encode_s(28, 10, 1), 32'h0000_101c, 32'h0fff_ffff);
        add_op('h48, encode_i('h401, 3, 3'b101, 11, `RV_OP_IMM));  // srai
        add_store('h4c, encode_s(32, 11, 1), 32'h0000_1020, 32'hffff_fffc);
        add_op('h50, encode_r(7'h00, 3, 2, 3'b110, 12));           // or
        add_store('h54, encode_s(36, 12, 1), 32'h0000_1024, 32'hffff_fffd);
        add_op('h58, encode_i('h0ff, 3, 3'b111, 13, `RV_OP_IMM));  // andi
        add_store('h5c, encode_s(40, 13, 1), 32'h0000_1028, 32'h0000_00f9);
        add_op('h60, encode_u('h12345, 14, `RV_OP_AUIPC));
        add_store('h64, encode_s(44, 14, 1), 32'h0000_102c, 32'h9234_5060);
        add_row('h68, encode_i(48, 1, 3'b010, 15, `RV_OP_LOAD), 32'hcafe_f00d, 1'b0,
            32'h0000_1030, '0);
        add_store('h6c, encode_s(52, 15, 1), 32'h0000_1034, 32'hcafe_f00d);
        add_op('h70, encode_i(5, 2, 3'b000, 0, `RV_OP_IMM));       // write to x0
        add_store('h74, encode_s(56, 0, 1), 32'h0000_1038, '0);
        // each branch once not taken, once taken by +8
        add_op('h78, encode_b(8, 3, 2, 3'b000));
        add_op('h7c, encode_b(8, 2, 2, 3'b000));
        add_op('h84, encode_b(8, 2, 2, 3'b001));
        add_op('h88, encode_b(8, 3, 2, 3'b001));
        add_op('h90, encode_b(8, 3, 2, 3'b100));
        add_op('h94, encode_b(8, 2, 3, 3'b100));
        add_op('h9c, encode_b(8, 2, 3, 3'b101));
        add_op('ha0, encode_b(8, 3, 2, 3'b101));
        add_op('ha8, encode_b(8, 2, 3, 3'b110));
        add_op('hac, encode_b(8, 3, 2, 3'b110));
        add_op('hb4, encode_b(8, 3, 2, 3'b111));
        add_op('hb8, encode_b(8, 2, 3, 3'b111));
        add_op('hc0, encode_j(16, 16));
        add_store('hd0, encode_s(60, 16, 1), 32'h0000_103c, 32'h8000_00c4);
        add_op('hd4, encode_u(0, 18, `RV_OP_AUIPC));
        add_op('hd8, encode_i('h31, 18, 3'b000, 17, `RV_OP_JALR)); // odd target, bit 0 dropped
        add_store('h104, encode_s(64, 17, 1), 32'h0000_1040, 32'h8000_00dc);
        add_op('h108, encode_j(-40, 0));
        add_op('he0, encode_b(-48, 0, 0, 3'b000));                 // backward beq
        add_store('hb0, encode_s(68, 7, 1), 32'h0000_1044, 32'h0000_0001);
        add_op('hb4, 32'h0000_000b);                               // custom-0, runs as nop
        add_store('hb8, encode_s(72, 2, 1), 32'h0000_1048, 32'h0000_0064);
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t expected,
        input rv_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0t: %s expected %08h, got %08h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the trace did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        imem_data  = `RV_NOP;
        dmem_rdata = '0;
        build_trace();
        cycle_limit = RESET_CYCLES + row_pc.size() + SLACK_CYCLES;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_bit("dmem_we in reset", 1'b0, dmem_we);
            if (i == RESET_CYCLES / 2) begin
                imem_data = encode_s(0, 0, 0);  // a store while reset still holds
            end
        end
        reset = 1'b0;

        foreach (row_pc[i]) begin
            check_word($sformatf("row %0d imem_addr", i), row_pc[i], imem_addr);
            imem_data  = row_inst[i];
            dmem_rdata = row_ldata[i];
            #SAMPLE_DELAY;
            check_bit($sformatf("row %0d dmem_we", i), row_we[i], dmem_we);
            if (row_we[i] || row_inst[i][6:0] == `RV_OP_LOAD) begin
                check_word($sformatf("row %0d dmem_addr", i), row_addr[i], dmem_addr);
            end
            if (row_we[i]) begin
                check_word($sformatf("row %0d dmem_wdata", i), row_wdata[i], dmem_wdata);
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end

        errors += dut_i.core_assert_i.failures;
        $display("checks: %0d, errors: %0d (assertion failures: %0d)",
            checks, errors, dut_i.core_assert_i.failures);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_control.sv
verilog/rv_imm_gen.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_pc_unit.sv
verilog/rv_core.sv
testbench/tb_clock.sv
testbench/rv_core_assert.sv
testbench/rv_core_tb.sv
